// File: logic/bus_l2_pkg.sv
`default_nettype none

package bus_l2_pkg;

	// Word address and data widths on the shared bus
	localparam int ADDR_W = 32;
	localparam int DATA_W = 32;

	// L2 geometry with two ways per set
	// Set index is the low address bits and the tag is what is left above it
	localparam int SET_BITS = 9;
	localparam int TAG_W = ADDR_W - SET_BITS;
	localparam int N_SETS = 1 << SET_BITS;

	// Bus operation carried with each request
	typedef enum logic {
		OP_READ  = 1'b0,
		OP_FLUSH = 1'b1
	} bus_op_t;

	// Result code returned with a read
	typedef enum logic [1:0] {
		HIT_NONE = 2'b00,
		HIT_PEER = 2'b01,
		HIT_L2   = 2'b10,
		HIT_MISS = 2'b11
	} hit_code_t;

	// What a core presents to the bus
	typedef struct packed {
		logic              valid;
		bus_op_t           op;
		logic [ADDR_W-1:0] addr;
		logic [DATA_W-1:0] wdata;
	} core_req_t;

	// Granted request tagged with its source core
	typedef struct packed {
		core_req_t cmd;
		logic      core;
	} bus_req_t;

	// Peer L1 answer to a snoop probe
	typedef struct packed {
		logic              hit;
		logic [DATA_W-1:0] data;
	} snoop_t;

	// Tag lookup result passed on to the data stage
	typedef struct packed {
		bus_req_t   req;
		logic [1:0] way_hit;
		logic       write_way;
		logic       l2_hit;
	} tag_result_t;

	// Response strobe toward a core
	typedef struct packed {
		logic              valid;
		hit_code_t         code;
		logic [DATA_W-1:0] data;
	} core_resp_t;

endpackage

`default_nettype wire

// File: logic/bus_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

// Stage 1 of the bus pipeline
// Picks one core per cycle and registers its request
module bus_arbiter (
	input  logic                                   clk,
	input  logic                                   reset,
	input  bus_l2_pkg::core_req_t [1:0]            req,
	output logic [1:0]                             grant,
	output bus_l2_pkg::bus_req_t                   bus_req,
	output logic [1:0]                             snoop_addr_valid,
	output logic [1:0][bus_l2_pkg::ADDR_W-1:0]     snoop_addr
);
	import bus_l2_pkg::*;

	// Round robin pointer where low favors core 0
	logic toggle_q;

	// Both cores asking in the same cycle
	logic both_req;

	// Index of the granted core which is 0 when nobody is granted
	logic win_core;

	// Probe is only sent for reads
	logic probe;

	assign both_req = req[0].valid && req[1].valid;

	// Grant is combinational so the request is taken at this edge
	// A lone requester always wins
	always_comb begin
		grant[0] = req[0].valid && (!req[1].valid || !toggle_q);
		grant[1] = req[1].valid && (!req[0].valid || toggle_q);
	end

	assign win_core = grant[1];

	// Flip the pointer only when there was a real conflict
	always_ff @(posedge clk) begin
		if (reset) begin
			toggle_q <= 1'b0;
		end else if (both_req) begin
			toggle_q <= !toggle_q;
		end
	end

	// Register the winner with its core number
	always_ff @(posedge clk) begin
		if (reset) begin
			bus_req.cmd.valid <= 1'b0;
		end else begin
			bus_req.cmd       <= req[win_core];
			bus_req.cmd.valid <= |grant;
			bus_req.core      <= win_core;
		end
	end

	assign probe = bus_req.cmd.valid && (bus_req.cmd.op == OP_READ);

	// Snoop goes to the opposite core in the cycle after acceptance
	// Peer answers one cycle later toward the data stage
	always_comb begin
		for (int c = 0; c < 2; c++) begin
			snoop_addr_valid[c] = probe && (int'(bus_req.core) != c);
			// Same address to both while only the valid bit selects the peer
			snoop_addr[c] = bus_req.cmd.addr;
		end
	end

endmodule

`default_nettype wire

// File: logic/l2_tag_stage.sv
`timescale 1ns/1ps
`default_nettype none

// Stage 2 of the bus pipeline
// Tag compare on both ways and flush victim choice
module l2_tag_stage (
	input  logic                    clk,
	input  logic                    reset,
	input  bus_l2_pkg::bus_req_t    bus_req,
	output bus_l2_pkg::tag_result_t tag_result
);
	import bus_l2_pkg::*;

	// Per set state, bit w belongs to way w
	logic [1:0] valid_q [N_SETS];
	logic [1:0] lru_q [N_SETS];

	// Tag store for both ways
	logic [TAG_W-1:0] tag_q [N_SETS][2];

	// Address split of the incoming request
	logic [SET_BITS-1:0] set_idx;
	logic [TAG_W-1:0]    req_tag;

	// Lookup results
	logic [1:0] way_hit;
	logic       write_way;
	logic       is_flush;

	assign set_idx  = bus_req.cmd.addr[SET_BITS-1:0];
	assign req_tag  = bus_req.cmd.addr[ADDR_W-1:SET_BITS];
	assign is_flush = bus_req.cmd.valid && (bus_req.cmd.op == OP_FLUSH);

	// Compare on both ways in parallel
	always_comb begin
		for (int w = 0; w < 2; w++) begin
			way_hit[w] = valid_q[set_idx][w] && (tag_q[set_idx][w] == req_tag);
		end
	end

	// Way a flush lands in
	// Matching line first, then a free way, way 0 before way 1
	always_comb begin
		if (way_hit[0]) begin
			write_way = 1'b0;
		end else if (way_hit[1]) begin
			write_way = 1'b1;
		end else if (!valid_q[set_idx][0]) begin
			write_way = 1'b0;
		end else if (!valid_q[set_idx][1]) begin
			write_way = 1'b1;
		end else begin
			// Set full, evict the way marked least recent
			write_way = lru_q[set_idx][1];
		end
	end

	// Valid and LRU update on a flush
	// Reads leave the LRU order alone
	always_ff @(posedge clk) begin
		if (reset) begin
			for (int s = 0; s < N_SETS; s++) begin
				valid_q[s] <= 2'b00;
				lru_q[s]   <= 2'b00;
			end
		end else if (is_flush) begin
			valid_q[set_idx][write_way] <= 1'b1;
			// Written way becomes most recent
			lru_q[set_idx][write_way]  <= 1'b0;
			lru_q[set_idx][!write_way] <= 1'b1;
		end
	end

	// Tag write for the chosen way
	always_ff @(posedge clk) begin
		if (is_flush) begin
			tag_q[set_idx][write_way] <= req_tag;
		end
	end

	// Carry the request and lookup into stage 3
	// A miss is just l2_hit low, no line is allocated here
	always_ff @(posedge clk) begin
		if (reset) begin
			tag_result.req.cmd.valid <= 1'b0;
		end else begin
			tag_result.req       <= bus_req;
			tag_result.way_hit   <= way_hit;
			tag_result.write_way <= write_way;
			tag_result.l2_hit    <= |way_hit;
		end
	end

endmodule

`default_nettype wire

// File: logic/l2_data_stage.sv
`timescale 1ns/1ps
`default_nettype none

// Stage 3 of the bus pipeline
// Data array access and response build
module l2_data_stage (
	input  logic                        clk,
	input  logic                        reset,
	input  bus_l2_pkg::tag_result_t     tag_result,
	input  bus_l2_pkg::snoop_t [1:0]    snoop,
	output bus_l2_pkg::core_resp_t      resp,
	output logic                        resp_core
);
	import bus_l2_pkg::*;

	// Data words per set and way
	logic [DATA_W-1:0] data_q [N_SETS][2];

	// Decoded view of the incoming lookup
	logic [SET_BITS-1:0] set_idx;
	logic                hit_way;
	logic                peer;
	logic                is_read;
	logic                is_flush;

	// Answer from the core opposite the requester
	snoop_t peer_snoop;

	// Word read from the hitting way
	logic [DATA_W-1:0] l2_word;

	// Response before the output register
	core_resp_t resp_d;

	assign set_idx = tag_result.req.cmd.addr[SET_BITS-1:0];

	// way_hit is one hot on a hit so bit 1 names the way
	assign hit_way = tag_result.way_hit[1];

	assign peer       = !tag_result.req.core;
	assign peer_snoop = snoop[peer];

	assign is_read  = tag_result.req.cmd.valid && (tag_result.req.cmd.op == OP_READ);
	assign is_flush = tag_result.req.cmd.valid && (tag_result.req.cmd.op == OP_FLUSH);

	// Flush data goes into the way stage 2 picked
	// Tag and valid already moved one edge earlier
	always_ff @(posedge clk) begin
		if (is_flush) begin
			data_q[set_idx][tag_result.write_way] <= tag_result.req.cmd.wdata;
		end
	end

	assign l2_word = data_q[set_idx][hit_way];

	// Peer copy beats the L2 copy
	// Miss returns zero data
	always_comb begin
		resp_d.valid = is_read;
		resp_d.code  = HIT_NONE;
		resp_d.data  = '0;
		if (is_read) begin
			if (peer_snoop.hit) begin
				resp_d.code = HIT_PEER;
				resp_d.data = peer_snoop.data;
			end else if (tag_result.l2_hit) begin
				resp_d.code = HIT_L2;
				resp_d.data = l2_word;
			end else begin
				resp_d.code = HIT_MISS;
			end
		end
	end

	// One cycle strobe back toward the requester
	// Flushes get no response
	always_ff @(posedge clk) begin
		if (reset) begin
			resp.valid <= 1'b0;
		end else begin
			resp      <= resp_d;
			resp_core <= tag_result.req.core;
		end
	end

endmodule

`default_nettype wire

// File: logic/bus_l2_top.sv
`timescale 1ns/1ps
`default_nettype none

// Shared bus and L2 for two cores
// Arbitrate, tag lookup, then data and response
module bus_l2_top (
	input  logic                                   clk,
	input  logic                                   reset,
	input  bus_l2_pkg::core_req_t [1:0]            req,
	output logic [1:0]                             grant,
	output logic [1:0]                             snoop_addr_valid,
	output logic [1:0][bus_l2_pkg::ADDR_W-1:0]     snoop_addr,
	input  bus_l2_pkg::snoop_t [1:0]               snoop,
	output bus_l2_pkg::core_resp_t [1:0]           resp
);
	import bus_l2_pkg::*;

	// Stage to stage records
	bus_req_t    bus_req;
	tag_result_t tag_result;

	// Shared response and its target core
	core_resp_t resp_int;
	logic       resp_core;

	bus_arbiter arbiter_i (
		.clk              (clk),
		.reset            (reset),
		.req              (req),
		.grant            (grant),
		.bus_req          (bus_req),
		.snoop_addr_valid (snoop_addr_valid),
		.snoop_addr       (snoop_addr)
	);

	l2_tag_stage tag_i (
		.clk        (clk),
		.reset      (reset),
		.bus_req    (bus_req),
		.tag_result (tag_result)
	);

	l2_data_stage data_i (
		.clk        (clk),
		.reset      (reset),
		.tag_result (tag_result),
		.snoop      (snoop),
		.resp       (resp_int),
		.resp_core  (resp_core)
	);

	// Fan out, only the requesting core sees valid
	always_comb begin
		for (int c = 0; c < 2; c++) begin
			resp[c]       = resp_int;
			resp[c].valid = resp_int.valid && (int'(resp_core) == c);
		end
	end

endmodule

`default_nettype wire

// File: tb/tb_bus_l2.sv
`timescale 1ns/1ps
`default_nettype none

module tb_bus_l2;
	import bus_l2_pkg::*;

	localparam int SEED = 32'hc98b;
	localparam int N_RANDOM = 40;
	localparam int PEER_WORDS = 4;

	logic clk = 1'b0;
	logic reset;
	core_req_t [1:0] req;
	logic [1:0] grant;
	logic [1:0] snoop_addr_valid;
	logic [1:0][ADDR_W-1:0] snoop_addr;
	snoop_t [1:0] snoop;
	core_resp_t [1:0] resp;

	// Expected read response and the cycle it is sampled in
	typedef struct packed {
		int                due;
		logic              core;
		hit_code_t         code;
		logic [DATA_W-1:0] data;
	} exp_resp_t;

	// Pending requests per core and responses in flight
	core_req_t stim_q [2][$];
	exp_resp_t exp_q [$];

	// Words each peer L1 holds
	logic [ADDR_W-1:0] peer_addr [2][PEER_WORDS];
	logic [DATA_W-1:0] peer_data [2][PEER_WORDS];

	// Reference L2 whose victim is the least recent way of a set
	logic [1:0]        ref_valid [N_SETS];
	logic              ref_victim [N_SETS];
	logic [TAG_W-1:0]  ref_tag [N_SETS][2];
	logic [DATA_W-1:0] ref_data [N_SETS][2];

	logic ref_toggle = 1'b0;
	logic [1:0] exp_probe_valid = 2'b00;
	logic [ADDR_W-1:0] exp_probe_addr;
	logic done = 1'b0;
	int cyc = 0;
	int limit;
	int errors = 0;
	int n_checks = 0;

	bus_l2_top dut_i (
		.clk              (clk),
		.reset            (reset),
		.req              (req),
		.grant            (grant),
		.snoop_addr_valid (snoop_addr_valid),
		.snoop_addr       (snoop_addr),
		.snoop            (snoop),
		.resp             (resp)
	);

	always #2 clk = ~clk;

	function automatic logic [ADDR_W-1:0] make_addr(int tag, int set);
		return {TAG_W'(tag), SET_BITS'(set)};
	endfunction

	function automatic core_req_t make_req(bus_op_t op, logic [ADDR_W-1:0] addr,
			logic [DATA_W-1:0] wdata);
		core_req_t r;
		r.valid = 1'b1;
		r.op = op;
		r.addr = addr;
		r.wdata = wdata;
		return r;
	endfunction

	// Lowest table entry wins on a duplicate address
	function automatic snoop_t lookup_peer(int c, logic [ADDR_W-1:0] addr);
		snoop_t s;
		s = '0;
		for (int i = PEER_WORDS - 1; i >= 0; i--) begin
			if (peer_addr[c][i] == addr) begin
				s.hit = 1'b1;
				s.data = peer_data[c][i];
			end
		end
		return s;
	endfunction

	function automatic void apply_flush(logic [ADDR_W-1:0] addr, logic [DATA_W-1:0] wdata);
		int s;
		logic [TAG_W-1:0] t;
		logic w;
		s = int'(addr[SET_BITS-1:0]);
		t = addr[ADDR_W-1:SET_BITS];
		// Matching line, then a free way, then the least recent one
		if (ref_valid[s][0] && ref_tag[s][0] == t)
			w = 1'b0;
		else if (ref_valid[s][1] && ref_tag[s][1] == t)
			w = 1'b1;
		else if (!ref_valid[s][0])
			w = 1'b0;
		else if (!ref_valid[s][1])
			w = 1'b1;
		else
			w = ref_victim[s];
		ref_valid[s][w] = 1'b1;
		ref_tag[s][w] = t;
		ref_data[s][w] = wdata;
		ref_victim[s] = !w;
	endfunction

	// Peer copy first, then L2, else a miss with zero data
	function automatic exp_resp_t predict_read(int c, logic [ADDR_W-1:0] addr, int due);
		exp_resp_t e;
		snoop_t p;
		int s;
		s = int'(addr[SET_BITS-1:0]);
		p = lookup_peer(1 - c, addr);
		e.due = due;
		e.core = 1'(c);
		e.code = HIT_MISS;
		e.data = '0;
		if (p.hit) begin
			e.code = HIT_PEER;
			e.data = p.data;
		end else begin
			for (int w = 0; w < 2; w++) begin
				if (ref_valid[s][w] && ref_tag[s][w] == addr[ADDR_W-1:SET_BITS]) begin
					e.code = HIT_L2;
					e.data = ref_data[s][w];
				end
			end
		end
		return e;
	endfunction

	// Any request gets exactly one grant
	assert property (@(posedge clk) disable iff (reset)
		(req[0].valid || req[1].valid) |-> $onehot(grant))
	else begin
		errors++;
		$display("FAILED grant_onehot: expected one grant, actual %b", grant);
	end

	// One bus slot probes at most one core
	assert property (@(posedge clk) disable iff (reset)
		!(snoop_addr_valid[0] && snoop_addr_valid[1]))
	else begin
		errors++;
		$display("FAILED probe_single: expected at most one, actual %b", snoop_addr_valid);
	end

	// Peer L1 answers the probe one edge after seeing it
	always @(posedge clk) begin
		for (int c = 0; c < 2; c++) begin
			if (snoop_addr_valid[c])
				snoop[c] <= lookup_peer(c, snoop_addr[c]);
			else
				snoop[c] <= '0;
		end
	end

	// Checks, reference update and request drive use pre-edge values
	always @(posedge clk) begin
		logic [1:0] exp_grant;
		exp_resp_t head;
		cyc <= cyc + 1;
		if (!reset) begin
			// Conflict goes to the toggle and a lone requester always wins
			exp_grant = {req[1].valid, req[0].valid};
			if (req[0].valid && req[1].valid) begin
				exp_grant = 2'b00;
				exp_grant[ref_toggle] = 1'b1;
				ref_toggle = !ref_toggle;
			end
			n_checks++;
			assert (grant == exp_grant) else begin
				errors++;
				$display("FAILED arbitration: expected %b, actual %b", exp_grant, grant);
			end
			for (int c = 0; c < 2; c++) begin
				n_checks++;
				assert (snoop_addr_valid[c] == exp_probe_valid[c]) else begin
					errors++;
					$display("FAILED snoop_probe core %0d: expected %b, actual %b",
						c, exp_probe_valid[c], snoop_addr_valid[c]);
				end
				if (exp_probe_valid[c]) begin
					assert (snoop_addr[c] == exp_probe_addr) else begin
						errors++;
						$display("FAILED snoop_addr core %0d: expected %h, actual %h",
							c, exp_probe_addr, snoop_addr[c]);
					end
				end
			end
			// Only the head can be due since one read is accepted per cycle
			n_checks++;
			if (exp_q.size() > 0 && exp_q[0].due == cyc) begin
				head = exp_q.pop_front();
				assert (resp[head.core].valid && !resp[!head.core].valid) else begin
					errors++;
					$display("FAILED resp_valid: expected core %0d, actual %b%b",
						head.core, resp[1].valid, resp[0].valid);
				end
				assert (resp[head.core].code == head.code) else begin
					errors++;
					$display("FAILED resp_code: expected %s, actual %s",
						head.code.name(), resp[head.core].code.name());
				end
				assert (resp[head.core].data == head.data) else begin
					errors++;
					$display("FAILED resp_data %s: expected %h, actual %h",
						head.code.name(), head.data, resp[head.core].data);
				end
			end else begin
				assert (!resp[0].valid && !resp[1].valid) else begin
					errors++;
					$display("FAILED resp_idle: expected 00, actual %b%b",
						resp[1].valid, resp[0].valid);
				end
			end
			// Accepted request updates the model in bus order
			exp_probe_valid = 2'b00;
			for (int c = 0; c < 2; c++) begin
				if (grant[c] && req[c].valid) begin
					if (req[c].op == OP_FLUSH) begin
						apply_flush(req[c].addr, req[c].wdata);
					end else begin
						exp_q.push_back(predict_read(c, req[c].addr, cyc + 3));
						exp_probe_valid[1 - c] = 1'b1;
						exp_probe_addr = req[c].addr;
					end
				end
			end
			// Nothing left to load, hold or answer
			done <= stim_q[0].size() == 0 && stim_q[1].size() == 0 && exp_q.size() == 0
				&& !req[0].valid && !req[1].valid;
			// Hold until granted, then load the next one or idle for a cycle
			for (int c = 0; c < 2; c++) begin
				if (!req[c].valid || grant[c]) begin
					if (stim_q[c].size() > 0 && $urandom_range(3) != 0)
						req[c] <= stim_q[c].pop_front();
					else
						req[c].valid <= 1'b0;
				end
			end
		end
	end

	always @(posedge clk) begin
		if (cyc >= limit) begin
			$display("Timeout after %0d cycles, %0d responses outstanding", cyc, exp_q.size());
			$display("Checks run: %0d, errors: %0d", n_checks, errors);
			$display("Checks failed");
			$finish;
		end
	end

	initial begin
		void'($urandom(SEED));
		reset = 1'b1;
		req = '0;
		snoop = '0;
		for (int s = 0; s < N_SETS; s++) begin
			ref_valid[s] = 2'b00;
			ref_victim[s] = 1'b0;
		end
		// Peer words live in sets 0 to 3 and directed tests use sets 8 to 10
		for (int c = 0; c < 2; c++) begin
			for (int i = 0; i < PEER_WORDS; i++) begin
				peer_addr[c][i] = make_addr($urandom_range(5), $urandom_range(3));
				peer_data[c][i] = $urandom;
			end
		end
		// Third tag evicts the first since the read in between leaves LRU alone
		stim_q[0].push_back(make_req(OP_FLUSH, make_addr(1, 8), 32'h1111_0001));
		stim_q[0].push_back(make_req(OP_FLUSH, make_addr(2, 8), 32'h2222_0002));
		stim_q[0].push_back(make_req(OP_READ, make_addr(1, 8), '0));
		stim_q[0].push_back(make_req(OP_FLUSH, make_addr(3, 8), 32'h3333_0003));
		stim_q[0].push_back(make_req(OP_READ, make_addr(1, 8), '0));
		stim_q[0].push_back(make_req(OP_READ, make_addr(2, 8), '0));
		stim_q[0].push_back(make_req(OP_READ, make_addr(3, 8), '0));
		stim_q[0].push_back(make_req(OP_READ, peer_addr[1][0], '0));
		// Fill, overwrite the matching way, then a plain miss
		stim_q[1].push_back(make_req(OP_FLUSH, make_addr(5, 9), 32'h5555_0005));
		stim_q[1].push_back(make_req(OP_READ, make_addr(5, 9), '0));
		stim_q[1].push_back(make_req(OP_FLUSH, make_addr(5, 9), 32'h5555_0006));
		stim_q[1].push_back(make_req(OP_READ, make_addr(5, 9), '0));
		stim_q[1].push_back(make_req(OP_READ, make_addr(7, 10), '0));
		stim_q[1].push_back(make_req(OP_READ, peer_addr[0][1], '0));
		// Random mix over a few sets so they fill and evict
		for (int c = 0; c < 2; c++) begin
			for (int i = 0; i < N_RANDOM; i++) begin
				if ($urandom_range(3) == 0)
					stim_q[c].push_back(make_req(OP_READ,
						peer_addr[1 - c][$urandom_range(PEER_WORDS - 1)], '0));
				else
					stim_q[c].push_back(make_req($urandom_range(1) ? OP_FLUSH : OP_READ,
						make_addr($urandom_range(5), $urandom_range(3)), $urandom));
			end
		end
		limit = 4 * (stim_q[0].size() + stim_q[1].size()) + 100;
		repeat (5) @(posedge clk);
		reset <= 1'b0;
		wait (done);
		@(posedge clk);
		$display("Checks run: %0d, errors: %0d", n_checks, errors);
		if (errors == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: all.f
logic/bus_l2_pkg.sv
logic/bus_arbiter.sv
logic/l2_tag_stage.sv
logic/l2_data_stage.sv
logic/bus_l2_top.sv
tb/tb_bus_l2.sv

// File: Bender.yml
package:
  name: bus_l2

sources:
  - files:
      - logic/bus_l2_pkg.sv
      - logic/bus_arbiter.sv
      - logic/l2_tag_stage.sv
      - logic/l2_data_stage.sv
      - logic/bus_l2_top.sv
  - target: test
    files:
      - tb/tb_bus_l2.sv
